// File: verilog/inner_pkg.sv
// Phase encoding is fixed at 4 bits and the command word at 6 bits; COUNT_W_DEF is only a default
package inner_pkg;

	// Command field width and default inner count width
	localparam int CMD_W       = 6;
	localparam int COUNT_W_DEF = 16;

	// Sequencer phase, numbered in walk order so later phases compare greater
	typedef enum logic [3:0] {
		idle       = 4'd0,
		src_readx  = 4'd1,
		src_zreadx = 4'd2,
		src_read   = 4'd3,
		src_zread  = 4'd4,
		dst_read   = 4'd5,
		dst_zread  = 4'd6,
		dst_write  = 4'd7,
		dst_zwrite = 4'd8
	} phase_e;

	// Bit positions inside the host command word
	typedef enum logic [2:0] {
		src_en_bit  = 3'd0,
		src_zen_bit = 3'd1,
		src_xen_bit = 3'd2,
		dst_en_bit  = 3'd3,
		dst_zen_bit = 3'd4,
		dst_zwr_bit = 3'd5
	} cmd_bit_e;

	// Phase enables; first member is the MSB, so src_en lands on bit 0
	typedef struct packed {
		logic dst_zwr;
		logic dst_zen;
		logic dst_en;
		logic src_xen;
		logic src_zen;
		logic src_en;
	} cmd_t;

endpackage

// File: verilog/phase_if.sv
// Carries one phase per cycle; step, read_issue and write_issue are single-cycle levels
`timescale 1ns/1ps

interface phase_if import inner_pkg::*; ();

	// Phase the sequencer is in this cycle
	phase_e phase;
	// High in the last cycle of the current phase
	logic   step;
	// Step of a read phase, one read request to memory
	logic   read_issue;
	// Step of a write phase with writes allowed
	logic   write_issue;

	// Sequencer side
	modport seq (
		output phase,
		output step,
		output read_issue,
		output write_issue
	);

	// Read tracker side
	modport trk (
		input phase,
		input step,
		input read_issue,
		input write_issue
	);

	// Spare read-only view, e.g. for a monitor
	modport mon (input phase, input step, input read_issue, input write_issue);

endinterface

// File: verilog/inner_cmd.sv
// A count of zero runs one pixel; a count load in the same cycle as a decrement takes priority
`timescale 1ns/1ps

module inner_cmd import inner_pkg::*; #(
	parameter int COUNT_W = COUNT_W_DEF
) (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic               cmd_ld,
	input  cmd_t               cmd_din,
	input  logic               count_ld,
	input  logic [COUNT_W-1:0] count_din,
	input  logic               count_dec,
	output cmd_t               cmd,
	output logic               last_pixel
);

	// Raw command bits as written by the host
	logic [CMD_W-1:0]   cmd_r;
	// Pixels left in the inner loop
	logic [COUNT_W-1:0] count_r;

	// Command register, loaded on the host strobe
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cmd_r <= '0;
		end else if (cmd_ld) begin
			cmd_r <= cmd_din;
		end
	end

	// Split the word into named enables by bit position
	always_comb begin
		cmd.src_en  = cmd_r[src_en_bit];
		cmd.src_zen = cmd_r[src_zen_bit];
		cmd.src_xen = cmd_r[src_xen_bit];
		cmd.dst_en  = cmd_r[dst_en_bit];
		cmd.dst_zen = cmd_r[dst_zen_bit];
		cmd.dst_zwr = cmd_r[dst_zwr_bit];
	end

	// Inner pixel counter
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			count_r <= '0;
		end else if (count_ld) begin
			count_r <= count_din;
		end else if (count_dec && (count_r != '0)) begin
			// Decrement at the end of each dst_write phase
			count_r <= count_r - 1'b1;
		end
	end

	// One pixel left before the dst_write step
	// Zero also counts as last so a zero count runs a single pixel
	assign last_pixel = (count_r <= COUNT_W'(1));

endmodule

// File: verilog/inner_seq.sv
// Waits on any unacknowledged read before leaving a phase; a command change mid-run is not supported
`timescale 1ns/1ps

module inner_seq import inner_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetl,
	input  logic   in_start,
	input  logic   mem_ready,
	input  logic   no_write,
	input  logic   read_wait,
	input  cmd_t   cmd,
	input  logic   last_pixel,
	output logic   count_dec,
	output logic   in_done,
	phase_if.seq   seq
);

	// Current phase
	phase_e phase_r;
	// Phase taken at the next step
	phase_e phase_nxt;
	// Start seen while busy, held for the next idle
	logic   start_l;
	logic   is_idle;
	logic   step;
	// Last phase of a pixel, dst_write or dst_zwrite
	logic   pix_end;
	logic   is_read;
	logic   is_write;
	// Last-pixel flag held from the dst_write step for dst_zwrite
	logic   last_l;
	// The pixel that ends now is the final one
	logic   run_end;

	// Whether a phase is enabled by the command
	function automatic logic phase_en(input phase_e p, input cmd_t c);
		case (p)
			src_readx:  return c.src_xen;
			src_zreadx: return c.src_xen & c.src_zen;
			src_read:   return c.src_en;
			src_zread:  return c.src_en & c.src_zen;
			dst_read:   return c.dst_en;
			dst_zread:  return c.dst_zen;
			dst_write:  return 1'b1;
			dst_zwrite: return c.dst_zwr;
			default:    return 1'b0;
		endcase
	endfunction

	// First enabled phase at or after first in walk order
	function automatic phase_e first_from(input phase_e first, input cmd_t c);
		phase_e res;
		logic   found;
		phase_e cand;
		// dst_write is always enabled, so this default is only a fallback
		res   = dst_write;
		found = 1'b0;
		for (int i = 1; i <= 8; i++) begin
			cand = phase_e'(4'(i));
			if (!found && (i >= int'(first)) && phase_en(cand, c)) begin
				res   = cand;
				found = 1'b1;
			end
		end
		return res;
	endfunction

	assign is_idle = (phase_r == idle);

	// dst_write closes the pixel unless a Z write follows
	assign pix_end = ((phase_r == dst_write) && !cmd.dst_zwr) || (phase_r == dst_zwrite);

	// dst_zwrite comes after the decrement and uses the flag held from dst_write
	assign run_end = (phase_r == dst_zwrite) ? last_l : last_pixel;

	// All phases before dst_write are reads
	assign is_read  = !is_idle && (phase_r < dst_write);
	assign is_write = (phase_r == dst_write) || (phase_r == dst_zwrite);

	// Idle steps at once on a start; otherwise memory and read data gate the step
	always_comb begin
		if (is_idle) begin
			step = in_start | start_l;
		end else begin
			step = mem_ready & ~read_wait;
		end
	end

	// Next phase by the fixed walk order
	always_comb begin
		if (is_idle) begin
			phase_nxt = first_from(src_readx, cmd);
		end else if (pix_end) begin
			// New pixel restarts at src_read since the extra read runs only once
			phase_nxt = run_end ? idle : first_from(src_read, cmd);
		end else begin
			phase_nxt = first_from(phase_e'(phase_r + 4'd1), cmd);
		end
	end

	// Phase register
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			phase_r <= idle;
		end else if (step) begin
			phase_r <= phase_nxt;
		end
	end

	// Hold the last-pixel flag across the count decrement
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			last_l <= 1'b0;
		end else if (count_dec) begin
			last_l <= last_pixel;
		end
	end

	// Start latch
	// In idle the start is consumed by the step of that same cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			start_l <= 1'b0;
		end else if (is_idle) begin
			start_l <= 1'b0;
		end else if (in_start) begin
			start_l <= 1'b1;
		end
	end

	// Done pulse one cycle after the final write step
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			in_done <= 1'b0;
		end else begin
			in_done <= step & pix_end & run_end;
		end
	end

	// Count one pixel per dst_write
	assign count_dec = step && (phase_r == dst_write);

	// Interface outputs
	assign seq.phase       = phase_r;
	assign seq.step        = step;
	assign seq.read_issue  = step & is_read;
	// no_write drops the request only and the walk still moves on
	assign seq.write_issue = step & is_write & ~no_write;

endmodule

// File: verilog/read_track.sv
// One acknowledge per cycle goes to the oldest pending read; reads return in issue order
`timescale 1ns/1ps

module read_track import inner_pkg::*; (
	input  logic sys_clk,
	input  logic resetl,
	input  logic read_ack,
	phase_if.trk trk,
	output logic read_wait,
	output logic src_data_read,
	output logic src_z_read,
	output logic dst_data_read,
	output logic dst_z_read
);

	// Read kinds, in phase order: 0 src data, 1 src Z, 2 dst data, 3 dst Z
	logic [3:0] pend;
	// Kind of the read issued this cycle
	logic [3:0] set;
	// Kind that takes this cycle's acknowledge
	logic [3:0] grant;

	// Decode the issued read; the extra reads share the src flags
	always_comb begin
		set = 4'b0000;
		if (trk.read_issue) begin
			case (trk.phase)
				src_readx, src_read:   set[0] = 1'b1;
				src_zreadx, src_zread: set[1] = 1'b1;
				dst_read:              set[2] = 1'b1;
				dst_zread:             set[3] = 1'b1;
				default:               set = 4'b0000;
			endcase
		end
	end

	// Oldest pending kind wins the acknowledge
	always_comb begin
		logic taken;
		taken = 1'b0;
		grant = 4'b0000;
		for (int i = 0; i < 4; i++) begin
			if (read_ack && pend[i] && !taken) begin
				grant[i] = 1'b1;
				taken    = 1'b1;
			end
		end
	end

	// Pending flags
	// A new read of the same kind re-arms the flag in the cycle the old one returns
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pend <= 4'b0000;
		end else begin
			pend <= set | (pend & ~grant);
		end
	end

	// Hold the sequencer while data is owed
	assign read_wait = (|pend) & ~read_ack;

	// Data strobes, valid in the acknowledge cycle
	assign src_data_read = grant[0];
	assign src_z_read    = grant[1];
	assign dst_data_read = grant[2];
	assign dst_z_read    = grant[3];

endmodule

// File: verilog/blit_inner.sv
// Blitter inner loop top; all logic on sys_clk, requests are combinational and need a same-cycle sample
`timescale 1ns/1ps

module blit_inner import inner_pkg::*; #(
	parameter int COUNT_W = COUNT_W_DEF
) (
	input  logic               sys_clk,
	input  logic               resetl,
	input  logic               cmd_ld,
	input  logic [CMD_W-1:0]   cmd_din,
	input  logic               count_ld,
	input  logic [COUNT_W-1:0] count_din,
	input  logic               in_start,
	input  logic               mem_ready,
	input  logic               read_ack,
	input  logic               no_write,
	output logic               read_req,
	output logic               write_req,
	output phase_e             phase,
	output logic               src_data_read,
	output logic               src_z_read,
	output logic               dst_data_read,
	output logic               dst_z_read,
	output logic               in_done
);

	// Registered enables and count state
	cmd_t cmd;
	logic last_pixel;
	logic count_dec;
	// Read tracker back-pressure to the sequencer
	logic read_wait;

	phase_if ph_if ();

	// Command and count registers
	inner_cmd #(
		.COUNT_W (COUNT_W)
	) cmd0 (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.cmd_ld     (cmd_ld),
		.cmd_din    (cmd_t'(cmd_din)),
		.count_ld   (count_ld),
		.count_din  (count_din),
		.count_dec  (count_dec),
		.cmd        (cmd),
		.last_pixel (last_pixel)
	);

	// Phase sequencer
	inner_seq seq0 (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.in_start   (in_start),
		.mem_ready  (mem_ready),
		.no_write   (no_write),
		.read_wait  (read_wait),
		.cmd        (cmd),
		.last_pixel (last_pixel),
		.count_dec  (count_dec),
		.in_done    (in_done),
		.seq        (ph_if.seq)
	);

	// Outstanding read tracking
	read_track trk0 (
		.sys_clk       (sys_clk),
		.resetl        (resetl),
		.read_ack      (read_ack),
		.trk           (ph_if.trk),
		.read_wait     (read_wait),
		.src_data_read (src_data_read),
		.src_z_read    (src_z_read),
		.dst_data_read (dst_data_read),
		.dst_z_read    (dst_z_read)
	);

	// Memory requests straight from the issue levels
	assign read_req  = ph_if.read_issue;
	assign write_req = ph_if.write_issue;
	assign phase     = ph_if.phase;

endmodule

// File: dv/tb_blit_inner.sv
// Reads dv/inner_testdata.txt from the project root; stops at the first mismatch or timeout
`timescale 1ns/1ps

module tb_blit_inner import inner_pkg::*; ();

	localparam int          COUNT_W     = 12;
	localparam int          HALF_PERIOD = 10;
	localparam int          RUN_TIMEOUT = 2000;
	localparam logic [31:0] SEED        = 32'h0e07_7c37;

	logic               sys_clk, resetl, cmd_ld, count_ld, in_start;
	logic               mem_ready, read_ack, no_write;
	logic [CMD_W-1:0]   cmd_din;
	logic [COUNT_W-1:0] count_din;
	logic               read_req, write_req, in_done;
	logic               src_data_read, src_z_read, dst_data_read, dst_z_read;
	phase_e             phase;

	// Reference state
	phase_e      exp_q[$];
	int          pend_q[$];
	phase_e      cur_exp;
	logic        done_exp, done_seen;
	logic [31:0] rng;
	int unsigned ack_max, ack_wait;

	blit_inner #(.COUNT_W(COUNT_W)) dut0 (.*);

	always #(HALF_PERIOD) sys_clk = ~sys_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic is_read_phase(input phase_e p);
		return (p != idle) && (p != dst_write) && (p != dst_zwrite);
	endfunction

	// Strobe index per read kind
	function automatic int read_kind(input phase_e p);
		case (p)
			src_readx, src_read:   return 0;
			src_zreadx, src_zread: return 1;
			dst_read:              return 2;
			default:               return 3;
		endcase
	endfunction

	// Expected walk; the count drops at dst_write, and one or zero left ends the run
	function automatic void build_ref(input logic [5:0] c, input int unsigned cnt);
		int unsigned left;
		logic        last;
		exp_q.delete();
		left = cnt;
		if (c[2]) exp_q.push_back(src_readx);
		if (c[2] && c[1]) exp_q.push_back(src_zreadx);
		do begin
			if (c[0]) exp_q.push_back(src_read);
			if (c[0] && c[1]) exp_q.push_back(src_zread);
			if (c[3]) exp_q.push_back(dst_read);
			if (c[4]) exp_q.push_back(dst_zread);
			exp_q.push_back(dst_write);
			last = (left <= 1);
			if (left != 0) left--;
			if (c[5]) exp_q.push_back(dst_zwrite);
		end while (!last);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Drive one clock after the edge and check it at the falling edge
	task automatic run_cycle(input logic start);
		logic       step_exp;
		logic [3:0] strobe_exp;
		@(posedge sys_clk);
		#2;
		in_start  = start;
		rng       = xorshift(rng);
		mem_ready = (rng[1:0] != 2'b00);
		read_ack  = 1'b0;
		if (pend_q.size() != 0) begin
			if (ack_wait == 0) read_ack = 1'b1;
			else ack_wait--;
		end
		@(negedge sys_clk);
		check_val("phase", phase, cur_exp);
		check_val("in_done", in_done, done_exp);
		if (done_exp) done_seen = 1'b1;
		if (cur_exp == idle) step_exp = start;
		else step_exp = mem_ready && ((pend_q.size() == 0) || read_ack);
		check_val("read_req", read_req, step_exp && is_read_phase(cur_exp));
		check_val("write_req", write_req,
			step_exp && (cur_exp >= dst_write) && !no_write);
		// Ack goes to the oldest outstanding read
		strobe_exp = 4'b0000;
		if (read_ack) begin
			strobe_exp[pend_q[0]] = 1'b1;
			void'(pend_q.pop_front());
		end
		check_val("data strobes", {dst_z_read, dst_data_read, src_z_read, src_data_read},
			strobe_exp);
		if (step_exp && is_read_phase(cur_exp)) begin
			pend_q.push_back(read_kind(cur_exp));
			rng      = xorshift(rng);
			ack_wait = rng % (ack_max + 1);
		end
		done_exp = 1'b0;
		if (step_exp) begin
			if ((cur_exp != idle) && (exp_q.size() == 0)) begin
				cur_exp  = idle;
				done_exp = 1'b1;
			end else begin
				cur_exp = exp_q.pop_front();
			end
		end
	endtask

	task automatic run_test(input logic [5:0] c, input logic [COUNT_W-1:0] cnt,
		input logic nw, input logic [31:0] seed, input int unsigned dly);
		int cycles;
		rng = SEED ^ seed;
		if (rng == 0) rng = SEED;
		ack_max = dly;
		build_ref(c, cnt);
		// Load the command and then the count one cycle apart
		@(posedge sys_clk);
		#2;
		cmd_ld   = 1'b1;
		cmd_din  = c;
		no_write = nw;
		@(posedge sys_clk);
		#2;
		cmd_ld    = 1'b0;
		count_ld  = 1'b1;
		count_din = cnt;
		@(posedge sys_clk);
		#2;
		count_ld  = 1'b0;
		cur_exp   = idle;
		done_exp  = 1'b0;
		done_seen = 1'b0;
		pend_q.delete();
		run_cycle(1'b1);
		cycles = 0;
		while (!done_seen) begin
			run_cycle(1'b0);
			cycles++;
			if (cycles > RUN_TIMEOUT)
				abort_run($sformatf("Timed out waiting for in_done, cmd 0x%0h", c));
		end
		// Quiet idle after done
		run_cycle(1'b0);
		run_cycle(1'b0);
	endtask

	initial begin
		int          fd, rc, ntests;
		string       line;
		logic [31:0] f_cmd, f_cnt, f_nw, f_seed, f_dly;
		sys_clk   = 1'b0;
		resetl    = 1'b0;
		cmd_ld    = 1'b0;
		cmd_din   = '0;
		count_ld  = 1'b0;
		count_din = '0;
		in_start  = 1'b0;
		mem_ready = 1'b0;
		read_ack  = 1'b0;
		no_write  = 1'b0;
		rng       = SEED;
		ntests    = 0;
		repeat (4) @(posedge sys_clk);
		#2;
		resetl = 1'b1;
		@(negedge sys_clk);
		check_val("phase", phase, idle);
		check_val("read_req", read_req, 1'b0);
		check_val("write_req", write_req, 1'b0);
		check_val("in_done", in_done, 1'b0);
		fd = $fopen("dv/inner_testdata.txt", "r");
		if (fd == 0) abort_run("Could not open the test data file");
		while (!$feof(fd)) begin
			line = "";
			rc   = $fgets(line, fd);
			// Skip comments and blank lines
			if ((line.len() > 2) && (line.getc(0) != "#")) begin
				rc = $sscanf(line, "%h %h %h %h %h", f_cmd, f_cnt, f_nw, f_seed, f_dly);
				if (rc != 5) abort_run({"Malformed test data line: ", line});
				run_test(f_cmd[5:0], f_cnt[COUNT_W-1:0], f_nw[0], f_seed, f_dly);
				ntests++;
			end
		end
		$fclose(fd);
		if (ntests == 0) begin
			abort_run("No tests found in the test data file");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

// File: dv/inner_testdata.txt
# Columns, all hex: command word, pixel count, no_write, seed, max acknowledge delay
# Command bits: 0 src_en, 1 src_zen, 2 src_xen, 3 dst_en, 4 dst_zen, 5 dst_zwr
00 0001 0 00000001 0
00 0000 0 00000002 1
08 0003 0 00000003 2
01 0005 1 00000004 3
07 0002 0 12345678 2
06 0003 0 0badcafe 4
18 0003 0 00c0ffee 1
20 0003 0 00000005 0
1b 0006 1 5a5a5a5a 3
3f 0004 0 0e077c37 3
3f 0001 1 deadbeef 5
2c 0003 0 00000007 6

// File: verilog.f
verilog/inner_pkg.sv
verilog/phase_if.sv
verilog/inner_cmd.sv
verilog/inner_seq.sv
verilog/read_track.sv
verilog/blit_inner.sv
dv/tb_blit_inner.sv

// File: Bender.yml
package:
  name: blit_inner

sources:
  # RTL in compile order
  - files:
      - verilog/inner_pkg.sv
      - verilog/phase_if.sv
      - verilog/inner_cmd.sv
      - verilog/inner_seq.sv
      - verilog/read_track.sv
      - verilog/blit_inner.sv

  # Testbench
  - target: test
    files:
      - dv/tb_blit_inner.sv
